// ==== hw/bcd_disp_params.svh ====
`ifndef BCD_DISP_PARAMS_SVH
`define BCD_DISP_PARAMS_SVH

// Converter sizes.
`define BIN_WIDTH     13
`define BCD_WIDTH     4
`define NUM_DIGITS    4
`define BIT_IDX_W     4     // Wide enough to count down from BIN_WIDTH.

// Display bus.
`define SEG_WIDTH     7

// Timing, in clock cycles.
`define REFRESH_DIV   64
`define REFRESH_CNT_W 6
`define SCAN_DIV      8
`define SCAN_CNT_W    3

`endif

// ==== hw/conv_pkg.sv ====
`default_nettype none

`include "bcd_disp_params.svh"

package conv_pkg;

    // One decimal digit, 0 to 9.
    typedef logic [`BCD_WIDTH-1:0] t_bcd_digit;

    typedef enum logic [1:0] {e_idle, e_shift, e_done} t_conv_state;

endpackage

`default_nettype wire

// ==== hw/disp_pkg.sv ====
`default_nettype none

`include "bcd_disp_params.svh"

package disp_pkg;

    // The digit currently lit, also the scanner state.
    typedef enum logic [1:0] {e_dig0, e_dig1, e_dig2, e_dig3} t_scan_digit;

    // Segments g down to a, active low.
    typedef logic [`SEG_WIDTH-1:0] t_seg;

    // Anodes, active low, bit n lights digit n.
    typedef logic [`NUM_DIGITS-1:0] t_anode;

    localparam t_seg   SEG_OFF = '1;
    localparam t_anode AN_OFF  = '1;

endpackage

`default_nettype wire

// ==== hw/bin_to_bcd.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bcd_disp_params.svh"

module bin_to_bcd
    import conv_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_start,
    input  logic [`BIN_WIDTH-1:0] i_bin,
    output logic                  o_ready,
    output logic                  o_done,
    output t_bcd_digit            o_bcd3,
    output t_bcd_digit            o_bcd2,
    output t_bcd_digit            o_bcd1,
    output t_bcd_digit            o_bcd0
);

    localparam int CHAIN_W = `NUM_DIGITS * `BCD_WIDTH + `BIN_WIDTH;

    t_conv_state r_state, w_state_next;
    logic [`BIT_IDX_W-1:0] r_index, w_index_next;
    logic [`BIN_WIDTH-1:0] r_bin, w_bin_next;
    t_bcd_digit r_bcd3, r_bcd2, r_bcd1, r_bcd0;
    t_bcd_digit w_bcd3_next, w_bcd2_next, w_bcd1_next, w_bcd0_next;
    logic [CHAIN_W-1:0] w_chain;

    // Digits above 4 would pass 9 after the shift, so they get 3 added first.
    function automatic t_bcd_digit add3(input t_bcd_digit d);
        return (d > 4'd4) ? d + 4'd3 : d;
    endfunction

    // Adjusted digits and the binary value, moved left as one chain.
    assign w_chain = {add3(r_bcd3), add3(r_bcd2), add3(r_bcd1), add3(r_bcd0), r_bin} << 1;

    always_comb
    begin
        w_state_next = r_state;
        w_index_next = r_index;
        w_bin_next   = r_bin;
        w_bcd3_next  = r_bcd3;
        w_bcd2_next  = r_bcd2;
        w_bcd1_next  = r_bcd1;
        w_bcd0_next  = r_bcd0;

        case (r_state)
            e_idle:
            begin
                if (i_start)
                begin
                    w_bin_next   = i_bin;
                    w_bcd3_next  = '0;
                    w_bcd2_next  = '0;
                    w_bcd1_next  = '0;
                    w_bcd0_next  = '0;
                    w_index_next = `BIT_IDX_W'(`BIN_WIDTH);
                    w_state_next = e_shift;
                end
            end
            e_shift:
            begin
                if (r_index == '0)
                begin
                    w_state_next = e_done; // All bits are in, this is the end-test cycle.
                end
                else
                begin
                    {w_bcd3_next, w_bcd2_next, w_bcd1_next, w_bcd0_next, w_bin_next} = w_chain;
                    w_index_next = r_index - 1'b1;
                end
            end
            e_done:
            begin
                w_state_next = e_idle;
            end
            default:
            begin
                w_state_next = e_idle;
            end
        endcase
    end

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state <= e_idle;
            r_index <= '0;
        end
        else
        begin
            r_state <= w_state_next;
            r_index <= w_index_next;
        end
    end

    // The result stays here after done until the next start clears it.
    always_ff @(posedge i_clk)
    begin
        r_bin  <= w_bin_next;
        r_bcd3 <= w_bcd3_next;
        r_bcd2 <= w_bcd2_next;
        r_bcd1 <= w_bcd1_next;
        r_bcd0 <= w_bcd0_next;
    end

    assign o_ready = (r_state == e_idle);
    assign o_done  = (r_state == e_done);
    assign o_bcd3  = r_bcd3;
    assign o_bcd2  = r_bcd2;
    assign o_bcd1  = r_bcd1;
    assign o_bcd0  = r_bcd0;

endmodule

`default_nettype wire

// ==== hw/refresh_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bcd_disp_params.svh"

module refresh_ctrl
    import conv_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic [`BIN_WIDTH-1:0] i_bin,
    output t_bcd_digit            o_digit3,
    output t_bcd_digit            o_digit2,
    output t_bcd_digit            o_digit1,
    output t_bcd_digit            o_digit0,
    output logic                  o_update
);

    logic [`REFRESH_CNT_W-1:0] r_refresh_cnt;
    logic w_tick;
    logic r_start;
    logic [`BIN_WIDTH-1:0] r_bin;
    logic r_update;
    t_bcd_digit r_digit3, r_digit2, r_digit1, r_digit0;

    logic w_start;
    logic [`BIN_WIDTH-1:0] w_bin;
    logic w_ready;
    logic w_done;
    t_bcd_digit w_bcd3, w_bcd2, w_bcd1, w_bcd0;

    assign w_tick  = (r_refresh_cnt == `REFRESH_CNT_W'(`REFRESH_DIV - 1));
    assign w_start = r_start;
    assign w_bin   = r_bin;

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_refresh_cnt <= '0;
            r_start       <= 1'b0;
            r_update      <= 1'b0;
            r_digit3      <= '0;
            r_digit2      <= '0;
            r_digit1      <= '0;
            r_digit0      <= '0;
        end
        else
        begin
            r_refresh_cnt <= w_tick ? '0 : r_refresh_cnt + 1'b1;
            r_start       <= w_tick && w_ready; // A busy converter just misses this tick.
            r_update      <= w_done;
            if (w_done)
            begin
                r_digit3 <= w_bcd3;
                r_digit2 <= w_bcd2;
                r_digit1 <= w_bcd1;
                r_digit0 <= w_bcd0;
            end
        end
    end

    // Sample of the input that goes with the start pulse.
    always_ff @(posedge i_clk)
    begin
        if (w_tick)
        begin
            r_bin <= i_bin;
        end
    end

    bin_to_bcd i_bin_to_bcd (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (w_start),
        .i_bin   (w_bin),
        .o_ready (w_ready),
        .o_done  (w_done),
        .o_bcd3  (w_bcd3),
        .o_bcd2  (w_bcd2),
        .o_bcd1  (w_bcd1),
        .o_bcd0  (w_bcd0)
    );

    assign o_digit3 = r_digit3;
    assign o_digit2 = r_digit2;
    assign o_digit1 = r_digit1;
    assign o_digit0 = r_digit0;
    assign o_update = r_update;

endmodule

`default_nettype wire

// ==== hw/seg_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bcd_disp_params.svh"

module seg_scan
    import conv_pkg::*;
    import disp_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  t_bcd_digit i_digit3,
    input  t_bcd_digit i_digit2,
    input  t_bcd_digit i_digit1,
    input  t_bcd_digit i_digit0,
    output t_seg       o_seg,
    output t_anode     o_an
);

    logic [`SCAN_CNT_W-1:0] r_scan_cnt;
    logic w_tick;
    t_scan_digit r_sel, w_sel;
    logic r_lit;
    t_bcd_digit w_digit;
    logic w_blank;
    t_seg w_seg;
    t_anode w_an;

    // Active-low patterns for gfedcba.
    function automatic t_seg seg_decode(input t_bcd_digit d);
        case (d)
            4'd0:    return 7'h40;
            4'd1:    return 7'h79;
            4'd2:    return 7'h24;
            4'd3:    return 7'h30;
            4'd4:    return 7'h19;
            4'd5:    return 7'h12;
            4'd6:    return 7'h02;
            4'd7:    return 7'h78;
            4'd8:    return 7'h00;
            4'd9:    return 7'h10;
            default: return SEG_OFF;
        endcase
    endfunction

    assign w_tick = (r_scan_cnt == `SCAN_CNT_W'(`SCAN_DIV - 1));
    assign w_sel  = w_tick ? t_scan_digit'(r_sel + 2'd1) : r_sel;

    always_comb
    begin
        case (w_sel)
            e_dig0:  w_digit = i_digit0;
            e_dig1:  w_digit = i_digit1;
            e_dig2:  w_digit = i_digit2;
            default: w_digit = i_digit3;
        endcase
    end

    // Leading zeros go dark, the units digit always shows.
    always_comb
    begin
        case (w_sel)
            e_dig3:  w_blank = (i_digit3 == '0);
            e_dig2:  w_blank = (i_digit3 == '0) && (i_digit2 == '0);
            e_dig1:  w_blank = (i_digit3 == '0) && (i_digit2 == '0) && (i_digit1 == '0);
            default: w_blank = 1'b0;
        endcase
    end

    assign w_seg = w_blank ? SEG_OFF : seg_decode(w_digit);
    assign w_an  = ~(t_anode'(1) << w_sel);

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_scan_cnt <= '0;
            r_sel      <= e_dig3; // So the first tick moves on to digit 0.
            r_lit      <= 1'b0;
            o_seg      <= SEG_OFF;
            o_an       <= AN_OFF;
        end
        else
        begin
            r_scan_cnt <= w_tick ? '0 : r_scan_cnt + 1'b1;
            r_sel      <= w_sel;
            if (w_tick)
            begin
                r_lit <= 1'b1;
                o_an  <= w_an;
            end
            // Segments follow the digit values every cycle once scanning runs.
            if (w_tick || r_lit)
            begin
                o_seg <= w_seg;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/bcd_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bcd_disp_params.svh"

module bcd_display_top
    import conv_pkg::*;
    import disp_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic [`BIN_WIDTH-1:0] i_bin,
    output t_bcd_digit            o_digit3,
    output t_bcd_digit            o_digit2,
    output t_bcd_digit            o_digit1,
    output t_bcd_digit            o_digit0,
    output logic                  o_update,
    output t_seg                  o_seg,
    output t_anode                o_an
);

    // Latched value, shared by the scanner and the outputs.
    t_bcd_digit w_disp3, w_disp2, w_disp1, w_disp0;

    refresh_ctrl i_refresh_ctrl (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_bin    (i_bin),
        .o_digit3 (w_disp3),
        .o_digit2 (w_disp2),
        .o_digit1 (w_disp1),
        .o_digit0 (w_disp0),
        .o_update (o_update)
    );

    seg_scan i_seg_scan (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_digit3 (w_disp3),
        .i_digit2 (w_disp2),
        .i_digit1 (w_disp1),
        .i_digit0 (w_disp0),
        .o_seg    (o_seg),
        .o_an     (o_an)
    );

    assign o_digit3 = w_disp3;
    assign o_digit2 = w_disp2;
    assign o_digit1 = w_disp1;
    assign o_digit0 = w_disp0;

endmodule

`default_nettype wire

// ==== test/tb_bcd_display.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bcd_disp_params.svh"

module tb_bcd_display
    import conv_pkg::*;
    import disp_pkg::*;
();

    localparam int NUM_ENTRIES    = 16;
    localparam int NUM_FIXED      = 12;
    localparam int SCAN_ROUND     = `NUM_DIGITS * `SCAN_DIV;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 3 * `REFRESH_DIV + 8 * SCAN_ROUND + 200;

    localparam int unsigned FIXED_VALUES [NUM_FIXED] = '{
        0, 7, 10, 99, 100, 909, 1000, 1234, 4095, 5005, 8191, 8191 - 9
    };

    // Active-low segments gfedcba for the decimal digits.
    localparam t_seg SEG_PATTERN [10] = '{
        7'b1000000,
        7'b1111001,
        7'b0100100,
        7'b0110000,
        7'b0011001,
        7'b0010010,
        7'b0000010,
        7'b1111000,
        7'b0000000,
        7'b0010000
    };

    logic                  i_clk;
    logic                  i_rst;
    logic [`BIN_WIDTH-1:0] i_bin;
    t_bcd_digit            o_digit3;
    t_bcd_digit            o_digit2;
    t_bcd_digit            o_digit1;
    t_bcd_digit            o_digit0;
    logic                  o_update;
    t_seg                  o_seg;
    t_anode                o_an;

    int unsigned stim_value [NUM_ENTRIES];
    t_bcd_digit  exp_digit [NUM_ENTRIES][`NUM_DIGITS];
    bit          scan_entry [NUM_ENTRIES];

    int         cycle;
    int         steps_since_rst;
    int         last_update_cycle;
    bit         seen_update;
    bit         prev_update;
    t_bcd_digit held_digit [`NUM_DIGITS];

    bcd_display_top i_bcd_display_top (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_bin    (i_bin),
        .o_digit3 (o_digit3),
        .o_digit2 (o_digit2),
        .o_digit1 (o_digit1),
        .o_digit0 (o_digit0),
        .o_update (o_update),
        .o_seg    (o_seg),
        .o_an     (o_an)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // Taps 16, 14, 13, 11.
    endfunction

    // Digit lit k cycles after reset release, once the first scan period is over.
    function automatic int lit_digit(input int k);
        return (k / `SCAN_DIV - 1) % `NUM_DIGITS;
    endfunction

    // Anodes expected k cycles after reset release.
    function automatic t_anode expected_anode(input int k);
        if (k < `SCAN_DIV)
        begin
            return '1;
        end
        return ~(t_anode'(1) << lit_digit(k));
    endfunction

    function automatic t_seg expected_seg(input int idx, input int n);
        bit blank;
        blank = (n > 0);
        for (int m = n; m < `NUM_DIGITS; m++)
        begin
            if (exp_digit[idx][m] != 0)
            begin
                blank = 1'b0;
            end
        end
        return blank ? t_seg'('1) : SEG_PATTERN[exp_digit[idx][n]];
    endfunction

    task automatic report_failure(input string msg);
        begin
            $display("%s", msg);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first failing check");
        end
    endtask

    task automatic compare_digit(input string name, input t_bcd_digit got, input t_bcd_digit exp);
        begin
            if (got !== exp)
            begin
                report_failure($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
            end
        end
    endtask

    task automatic compare_seg(input string name, input t_seg got, input t_seg exp);
        begin
            if (got !== exp)
            begin
                report_failure($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
            end
        end
    endtask

    task automatic compare_an(input string name, input t_anode got, input t_anode exp);
        begin
            if (got !== exp)
            begin
                report_failure($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
            end
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        begin
            if (got !== exp)
            begin
                report_failure($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
            end
        end
    endtask

    // One clock cycle, with the checks that hold in every cycle.
    task automatic step();
        begin
            @(negedge i_clk);
            cycle++;
            steps_since_rst++;
            if (cycle >= TIMEOUT_CYCLES)
            begin
                report_failure($sformatf("timeout after %0d cycles, tests did not finish", cycle));
            end
            compare_an("o_an", o_an, expected_anode(steps_since_rst));
            if (o_update === 1'b1)
            begin
                if (prev_update)
                begin
                    report_failure("o_update stayed high for more than one cycle");
                end
                if (seen_update)
                begin
                    compare_count("update spacing", cycle - last_update_cycle, `REFRESH_DIV);
                end
                seen_update       = 1'b1;
                last_update_cycle = cycle;
                held_digit[3]     = o_digit3;
                held_digit[2]     = o_digit2;
                held_digit[1]     = o_digit1;
                held_digit[0]     = o_digit0;
            end
            else
            begin
                compare_digit("o_digit3", o_digit3, held_digit[3]); // Unchanged between pulses.
                compare_digit("o_digit2", o_digit2, held_digit[2]);
                compare_digit("o_digit1", o_digit1, held_digit[1]);
                compare_digit("o_digit0", o_digit0, held_digit[0]);
            end
            prev_update = (o_update === 1'b1);
        end
    endtask

    task automatic wait_update();
        begin
            step();
            while (o_update !== 1'b1)
            begin
                step();
            end
        end
    endtask

    task automatic check_scan_rounds(input int idx);
        int n;
        begin
            repeat (2 * SCAN_ROUND)
            begin
                step();
                n = lit_digit(steps_since_rst);
                compare_seg($sformatf("o_seg digit %0d", n), o_seg, expected_seg(idx, n));
            end
        end
    endtask

    initial
    begin
        int unsigned value;
        logic [15:0] lfsr;

        for (int idx = 0; idx < NUM_FIXED; idx++)
        begin
            stim_value[idx] = FIXED_VALUES[idx];
        end
        lfsr = 16'd22;
        for (int idx = NUM_FIXED; idx < NUM_ENTRIES; idx++)
        begin
            value = 0;
            for (int b = 0; b < `BIN_WIDTH; b++)
            begin
                lfsr  = lfsr_next(lfsr);
                value = (value << 1) | lfsr[0];
            end
            stim_value[idx] = value;
        end
        for (int idx = 0; idx < NUM_ENTRIES; idx++)
        begin
            value = stim_value[idx];
            for (int d = 0; d < `NUM_DIGITS; d++)
            begin
                exp_digit[idx][d] = t_bcd_digit'(value % 10);
                value             = value / 10;
            end
            scan_entry[idx] = (idx < NUM_FIXED) && (stim_value[idx] == 0 || stim_value[idx] == 7
                              || stim_value[idx] == 100 || stim_value[idx] == 8191);
        end

        cycle             = 0;
        steps_since_rst   = 0;
        last_update_cycle = 0;
        seen_update       = 1'b0;
        prev_update       = 1'b0;
        for (int d = 0; d < `NUM_DIGITS; d++)
        begin
            held_digit[d] = '0;
        end

        i_rst = 1'b1;
        i_bin = '0;
        repeat (2) @(negedge i_clk);
        compare_an("o_an", o_an, '1);
        compare_seg("o_seg", o_seg, '1);
        compare_count("o_update", int'(o_update), 0);
        compare_digit("o_digit3", o_digit3, '0);
        compare_digit("o_digit2", o_digit2, '0);
        compare_digit("o_digit1", o_digit1, '0);
        compare_digit("o_digit0", o_digit0, '0);
        i_rst = 1'b0;

        for (int idx = 0; idx < NUM_ENTRIES; idx++)
        begin
            i_bin = stim_value[idx][`BIN_WIDTH-1:0];
            wait_update(); // May still hold the previous value.
            wait_update();
            compare_digit("o_digit3", o_digit3, exp_digit[idx][3]);
            compare_digit("o_digit2", o_digit2, exp_digit[idx][2]);
            compare_digit("o_digit1", o_digit1, exp_digit[idx][1]);
            compare_digit("o_digit0", o_digit0, exp_digit[idx][0]);
            if (scan_entry[idx])
            begin
                check_scan_rounds(idx);
            end
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hw
hw/conv_pkg.sv
hw/disp_pkg.sv
hw/bin_to_bcd.sv
hw/refresh_ctrl.sv
hw/seg_scan.sv
hw/bcd_display_top.sv
test/tb_bcd_display.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_bcd_display -f flist.f > build.log 2>&1 \
    || { cat build.log; echo "Build failed."; exit 1; }

./obj_dir/Vtb_bcd_display > sim.log 2>&1
cat sim.log

grep -qx "ALL CHECKS PASSED" sim.log \
    && echo "Simulation passed." \
    || { echo "Simulation failed."; exit 1; }
